// ==== Bender.yml ====
package:
  name: dungeon

sources:
  - game_pkg.sv
  - video_pkg.sv
  - vga_timing.sv
  - button_latch.sv
  - game_control.sv
  - dragon_chaser.sv
  - tile_renderer.sv
  - dungeon_top.sv
  - target: simulation
    files:
      - dungeon_tb.sv

// ==== button_latch.sv ====
`timescale 1ns/1ps

module button_latch import game_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  buttons_t buttons,
    input  logic     frame_tick,
    output buttons_t pressed
);

    buttons_t meta;                 // first synchroniser stage
    buttons_t sync;                 // second stage, safe to use
    buttons_t sync_d;               // previous level for edge detect
    buttons_t rise;

    assign rise = sync & ~sync_d;   // 0 -> 1 per button

    always_ff @(posedge clk) begin
        if (!reset) begin
            meta    <= '0;
            sync    <= '0;
            sync_d  <= '0;
            pressed <= '0;
        end else begin
            meta   <= buttons;
            sync   <= meta;
            sync_d <= sync;
            // presses pile up between ticks, the tick consumes them
            if (frame_tick) begin
                pressed <= rise;    // an edge in the tick cycle waits a frame
            end else begin
                pressed <= pressed | rise;
            end
        end
    end

endmodule

// ==== dragon_chaser.sv ====
`timescale 1ns/1ps

module dragon_chaser import game_pkg::*; #(
    parameter int CHASE_FRAMES = 10
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      frame_tick,
    input  tile_pos_t player_pos,
    output tile_pos_t dragon_pos
);

    localparam int               CNT_W   = $clog2(CHASE_FRAMES + 1);
    localparam logic [CNT_W-1:0] STEP_AT = CNT_W'(CHASE_FRAMES);

    logic [CNT_W-1:0] tick_cnt;     // slows the dragon down
    tile_x_t          dist_x;
    tile_y_t          dist_y;
    logic             go_right;
    logic             go_down;
    tile_pos_t        next_pos;

    // true when b is one tile from a along a single axis
    function automatic logic one_step(tile_pos_t a, tile_pos_t b);
        tile_x_t ex;
        tile_y_t ey;
        ex = b.x - a.x;
        ey = b.y - a.y;
        return ((ex == '0) && ((ey == 4'd1) || (ey == 4'hf))) ||
               ((ey == '0) && ((ex == 4'd1) || (ex == 4'hf)));
    endfunction

    // greedy step, the longer axis first, x on a tie
    always_comb begin
        go_right = player_pos.x > dragon_pos.x;
        go_down  = player_pos.y > dragon_pos.y;
        dist_x   = go_right ? player_pos.x - dragon_pos.x : dragon_pos.x - player_pos.x;
        dist_y   = go_down  ? player_pos.y - dragon_pos.y : dragon_pos.y - player_pos.y;
        next_pos = dragon_pos;
        if ((dist_x != '0) && (dist_x >= dist_y)) begin
            next_pos.x = go_right ? dragon_pos.x + 1'b1 : dragon_pos.x - 1'b1;
        end else if (dist_y != '0) begin
            next_pos.y = go_down ? dragon_pos.y + 1'b1 : dragon_pos.y - 1'b1;
        end
        // on the player's tile next_pos == dragon_pos
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            tick_cnt   <= '0;
            dragon_pos <= '0;
        end else if (frame_tick) begin
            if (tick_cnt == STEP_AT) begin
                tick_cnt   <= '0;
                dragon_pos <= next_pos;     // uses pos from before this tick
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // moves happen only right after a tick and never jump
    ap_single_step: assert property (@(posedge clk) disable iff (!reset)
        $past(reset) && (dragon_pos != $past(dragon_pos)) |->
            $past(frame_tick) && one_step($past(dragon_pos), dragon_pos))
        else $error("dragon moved off-tick or more than one tile");

endmodule

// ==== dungeon_tb.sv ====
`timescale 1ns/1ps

module dungeon_tb import game_pkg::*, video_pkg::*; ();

    // small screen of 80 clocks per line and 54 lines per frame
    localparam int TILE_PIXELS  = 4;
    localparam int SWORD_FRAMES = 2;
    localparam int CHASE_FRAMES = 3;
    localparam int LINE_CYCLES  = 80;
    localparam int FRAME_LINES  = 54;
    localparam int H_SYNC_LEN   = 8;      // clocks per hsync pulse
    localparam int V_SYNC_LEN   = 2;      // lines per vsync pulse
    localparam int FRAME_CYCLES = 4320;
    localparam int HOLD_CYCLES  = 10;     // button held this long after a tick
    localparam int N_STEPS      = 26;
    localparam int N_RANDOM     = 40;

    localparam buttons_t B_NONE   = 5'b00000;
    localparam buttons_t B_UP     = 5'b00001;
    localparam buttons_t B_DOWN   = 5'b00010;
    localparam buttons_t B_LEFT   = 5'b00100;
    localparam buttons_t B_RIGHT  = 5'b01000;
    localparam buttons_t B_ATTACK = 5'b10000;

    // one table row holds buttons pressed for a run of frames
    typedef struct packed {
        buttons_t      buttons;
        int            frames;
        player_state_t result;          // player after the last frame of the run
    } step_t;

    logic          clk;
    logic          reset;
    buttons_t      buttons;
    logic          hsync;
    logic          vsync;
    rgb_t          rgb;
    logic          frame_tick;
    player_state_t player;
    tile_pos_t     dragon_pos;

    step_t         steps [N_STEPS];
    logic [31:0]   lfsr;
    int            cycles;
    int            cycle_limit;
    int            player_pix;          // colour counts over the current frame
    int            dragon_pix;
    int            hsync_cyc;           // sync counts over the current frame
    int            vsync_cyc;
    logic          full_frame;          // first frame after reset is short

    // reference model state
    player_state_t m_player;
    int            m_sword_left;        // ticks until the sword goes away
    tile_pos_t     m_dragon;
    int            m_chase_wait;

    dungeon_top #(
        .H_DISPLAY    (64),
        .H_FRONT      (4),
        .H_SYNC       (H_SYNC_LEN),
        .H_BACK       (4),
        .V_DISPLAY    (48),
        .V_FRONT      (2),
        .V_SYNC       (V_SYNC_LEN),
        .V_BACK       (2),
        .TILE_PIXELS  (TILE_PIXELS),
        .SWORD_FRAMES (SWORD_FRAMES),
        .CHASE_FRAMES (CHASE_FRAMES)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .buttons    (buttons),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb        (rgb),
        .frame_tick (frame_tick),
        .player     (player),
        .dragon_pos (dragon_pos)
    );

    always #50 clk = ~clk;              // 100 ns period

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, frame_tick stopped coming",
                cycles));
        end
    end

    function automatic string fmt_tile(tile_pos_t p);
        return $sformatf("(%0d,%0d)", p.x, p.y);
    endfunction

    function automatic string fmt_player(player_state_t p);
        return $sformatf("pos=%s facing=%0d sword_on=%0b sword_pos=%s",
            fmt_tile(p.pos), p.facing, p.sword_on, fmt_tile(p.sword_pos));
    endfunction

    task automatic check_player(input string name, input player_state_t got,
                                input player_state_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %s expected %s",
                $time, name, fmt_player(got), fmt_player(exp)));
        end
    endtask

    task automatic check_tile(input string name, input tile_pos_t got, input tile_pos_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %s expected %s",
                $time, name, fmt_tile(got), fmt_tile(exp)));
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic player_state_t player_at(int x, int y, dir_t f, logic s,
                                                int sx, int sy);
        player_state_t p;
        p.pos       = '{x: tile_x_t'(x), y: tile_y_t'(y)};
        p.facing    = f;
        p.sword_on  = s;
        p.sword_pos = '{x: tile_x_t'(sx), y: tile_y_t'(sy)};
        return p;
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic buttons_t random_buttons();
        buttons_t b;
        b.up     = take_bit();
        b.down   = take_bit();
        b.left   = take_bit();
        b.right  = take_bit();
        b.attack = take_bit() & take_bit();   // attack about one frame in four
        return b;
    endfunction

    task automatic load_table();
        steps[0]  = '{B_NONE, 1, player_at(7, 6, DIR_RIGHT, 0, 0, 0)};
        steps[1]  = '{B_RIGHT, 1, player_at(8, 6, DIR_RIGHT, 0, 0, 0)};
        steps[2]  = '{B_UP, 1, player_at(8, 5, DIR_UP, 0, 0, 0)};
        steps[3]  = '{B_RIGHT | B_LEFT | B_UP, 1, player_at(9, 5, DIR_RIGHT, 0, 0, 0)};
        steps[4]  = '{B_DOWN | B_LEFT, 1, player_at(8, 5, DIR_LEFT, 0, 0, 0)};
        steps[5]  = '{B_DOWN | B_UP, 1, player_at(8, 6, DIR_DOWN, 0, 0, 0)};
        steps[6]  = '{B_ATTACK, 1, player_at(8, 6, DIR_DOWN, 1, 8, 7)};
        steps[7]  = '{B_LEFT, 1, player_at(8, 6, DIR_DOWN, 1, 8, 7)};    // ignored
        steps[8]  = '{B_RIGHT, 1, player_at(8, 6, DIR_DOWN, 0, 8, 7)};   // sword ends
        steps[9]  = '{B_UP, 1, player_at(8, 5, DIR_UP, 0, 8, 7)};
        steps[10] = '{B_ATTACK | B_RIGHT, 1, player_at(8, 5, DIR_UP, 1, 8, 4)};
        steps[11] = '{B_NONE, 2, player_at(8, 5, DIR_UP, 0, 8, 4)};
        steps[12] = '{B_UP, 5, player_at(8, 1, DIR_UP, 0, 8, 4)};       // top row stops it
        steps[13] = '{B_ATTACK, 1, player_at(8, 1, DIR_UP, 1, 8, 0)};
        steps[14] = '{B_NONE, 2, player_at(8, 1, DIR_UP, 0, 8, 0)};
        steps[15] = '{B_LEFT, 9, player_at(0, 1, DIR_LEFT, 0, 8, 0)};
        steps[16] = '{B_ATTACK, 1, player_at(0, 1, DIR_LEFT, 1, 15, 1)}; // wraps
        steps[17] = '{B_NONE, 2, player_at(0, 1, DIR_LEFT, 0, 15, 1)};
        steps[18] = '{B_UP, 1, player_at(0, 1, DIR_UP, 0, 15, 1)};       // turn only
        steps[19] = '{B_NONE, 22, player_at(0, 1, DIR_UP, 0, 15, 1)};    // dragon catches up
        steps[20] = '{B_RIGHT, 16, player_at(15, 1, DIR_RIGHT, 0, 15, 1)};
        steps[21] = '{B_ATTACK, 1, player_at(15, 1, DIR_RIGHT, 1, 0, 1)};
        steps[22] = '{B_NONE, 2, player_at(15, 1, DIR_RIGHT, 0, 0, 1)};
        steps[23] = '{B_DOWN, 11, player_at(15, 11, DIR_DOWN, 0, 0, 1)};
        steps[24] = '{B_ATTACK, 1, player_at(15, 11, DIR_DOWN, 1, 15, 12)};
        steps[25] = '{B_NONE, 2, player_at(15, 11, DIR_DOWN, 0, 15, 12)};
    endtask

    // ------------------------------------------------------------------------
    // reference model called once per frame tick
    // ------------------------------------------------------------------------
    function automatic int dir_dx(dir_t d);
        return (d == DIR_RIGHT) ? 1 : (d == DIR_LEFT) ? -1 : 0;
    endfunction

    function automatic int dir_dy(dir_t d);
        return (d == DIR_DOWN) ? 1 : (d == DIR_UP) ? -1 : 0;
    endfunction

    task automatic model_tick(input buttons_t b);
        tile_pos_t pre;
        dir_t      d;
        int        dx;
        int        dy;
        int        nx;
        int        ny;
        pre = m_player.pos;             // dragon sees the player before the move
        m_chase_wait++;
        if (m_chase_wait > CHASE_FRAMES) begin
            m_chase_wait = 0;
            dx = int'(pre.x) - int'(m_dragon.x);
            dy = int'(pre.y) - int'(m_dragon.y);
            if ((dx != 0) && ((dx < 0 ? -dx : dx) >= (dy < 0 ? -dy : dy))) begin
                m_dragon.x = tile_x_t'(int'(m_dragon.x) + (dx > 0 ? 1 : -1));
            end else if (dy != 0) begin
                m_dragon.y = tile_y_t'(int'(m_dragon.y) + (dy > 0 ? 1 : -1));
            end
        end
        if (m_sword_left > 0) begin     // buttons dropped while swinging
            m_sword_left--;
            if (m_sword_left == 0) m_player.sword_on = 1'b0;
        end else if (b.attack) begin
            m_sword_left       = SWORD_FRAMES;
            m_player.sword_on  = 1'b1;
            m_player.sword_pos = '{x: tile_x_t'(pre.x + dir_dx(m_player.facing)),
                                   y: tile_y_t'(pre.y + dir_dy(m_player.facing))};
        end else if (b.right || b.left || b.down || b.up) begin
            d = b.right ? DIR_RIGHT : b.left ? DIR_LEFT : b.down ? DIR_DOWN : DIR_UP;
            m_player.facing = d;
            nx = int'(pre.x) + dir_dx(d);
            ny = int'(pre.y) + dir_dy(d);
            if ((nx >= 0) && (nx <= 15) && (ny >= 1) && (ny <= 11)) begin
                m_player.pos = '{x: tile_x_t'(nx), y: tile_y_t'(ny)};
            end
        end
    endtask

    // dragon hidden under the player or the lit sword
    function automatic int dragon_pixels_expected();
        if ((m_dragon == m_player.pos) ||
            (m_player.sword_on && (m_dragon == m_player.sword_pos))) begin
            return 0;
        end
        return TILE_PIXELS * TILE_PIXELS;
    endfunction

    // ------------------------------------------------------------------------
    // clocking and frame sequencing
    // ------------------------------------------------------------------------
    // every edge goes through here so the colour monitor sees them all
    task automatic step_clock();
        @(posedge clk);
        if (hsync || vsync) check_rgb("rgb", rgb, COL_BLACK);
        if (rgb == COL_PLAYER) player_pix++;
        if (rgb == COL_DRAGON) dragon_pix++;
        if (hsync) hsync_cyc++;
        if (vsync) vsync_cyc++;
    endtask

    task automatic wait_tick();
        step_clock();
        while (!frame_tick) step_clock();
    endtask

    task automatic play_frame(input buttons_t b);
        buttons <= b;
        repeat (HOLD_CYCLES) step_clock();
        buttons <= B_NONE;
        wait_tick();
        // the frame just drawn shows the state from before this tick
        check_count("player pixels", player_pix, TILE_PIXELS * TILE_PIXELS);
        check_count("dragon pixels", dragon_pix, dragon_pixels_expected());
        if (full_frame) begin
            check_count("hsync cycles", hsync_cyc, H_SYNC_LEN * FRAME_LINES);
            check_count("vsync cycles", vsync_cyc, V_SYNC_LEN * LINE_CYCLES);
        end
        full_frame = 1'b1;
        player_pix = 0;
        dragon_pix = 0;
        hsync_cyc  = 0;
        vsync_cyc  = 0;
        model_tick(b);
        step_clock();                   // results land one cycle after the tick
        check_player("player", player, m_player);
        check_tile("dragon_pos", dragon_pos, m_dragon);
    endtask

    initial begin
        int total;
        clk          = 1'b0;
        reset        = 1'b0;
        buttons      = B_NONE;
        cycles       = 0;
        player_pix   = 0;
        dragon_pix   = 0;
        hsync_cyc    = 0;
        vsync_cyc    = 0;
        full_frame   = 1'b0;
        lfsr         = 32'h5e12016e;
        m_player     = player_at(7, 6, DIR_RIGHT, 0, 0, 0);
        m_sword_left = 0;
        m_dragon     = '0;
        m_chase_wait = 0;
        load_table();
        total = N_RANDOM;
        foreach (steps[i]) total += steps[i].frames;
        cycle_limit = (total + 4) * FRAME_CYCLES;

        repeat (5) step_clock();
        reset <= 1'b1;
        check_player("player", player, m_player);     // reset values
        check_tile("dragon_pos", dragon_pos, m_dragon);
        player_pix = 0;
        dragon_pix = 0;
        hsync_cyc  = 0;
        vsync_cyc  = 0;

        foreach (steps[i]) begin
            for (int k = 0; k < steps[i].frames; k++) begin
                play_frame(steps[i].buttons);
            end
            check_player("player", player, steps[i].result);
        end
        for (int r = 0; r < N_RANDOM; r++) begin
            play_frame(random_buttons());
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== dungeon_top.sv ====
`timescale 1ns/1ps

module dungeon_top import game_pkg::*; import video_pkg::*; #(
    parameter int        H_DISPLAY    = 640,
    parameter int        H_FRONT      = 16,
    parameter int        H_SYNC       = 96,
    parameter int        H_BACK       = 48,
    parameter int        V_DISPLAY    = 480,
    parameter int        V_FRONT      = 10,
    parameter int        V_SYNC       = 2,
    parameter int        V_BACK       = 33,
    parameter int        TILE_PIXELS  = 40,
    parameter int        SWORD_FRAMES = 10,
    parameter int        CHASE_FRAMES = 10,
    parameter tile_pos_t START_POS    = '{x: 4'd7, y: 4'd6}
) (
    input  logic          clk,
    input  logic          reset,
    input  buttons_t      buttons,      // raw, asynchronous
    output logic          hsync,
    output logic          vsync,
    output rgb_t          rgb,
    output logic          frame_tick,
    output player_state_t player,
    output tile_pos_t     dragon_pos
);

    pix_t     pix_x;
    pix_t     pix_y;
    logic     display_on;
    buttons_t pressed;              // presses since the last tick

    // ------------------------------------------------------------------------
    // video timing
    // ------------------------------------------------------------------------
    vga_timing #(
        .H_DISPLAY (H_DISPLAY),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_DISPLAY (V_DISPLAY),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) vga_timing0 (
        .clk        (clk),
        .reset      (reset),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .display_on (display_on),
        .hsync      (hsync),
        .vsync      (vsync),
        .frame_tick (frame_tick)
    );

    // ------------------------------------------------------------------------
    // game logic, all stepping on frame_tick
    // ------------------------------------------------------------------------
    button_latch button_latch0 (
        .clk        (clk),
        .reset      (reset),
        .buttons    (buttons),
        .frame_tick (frame_tick),
        .pressed    (pressed)
    );

    game_control #(
        .SWORD_FRAMES (SWORD_FRAMES),
        .START_POS    (START_POS)
    ) game_control0 (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .pressed    (pressed),
        .player     (player)
    );

    dragon_chaser #(
        .CHASE_FRAMES (CHASE_FRAMES)
    ) dragon_chaser0 (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .player_pos (player.pos),   // chases the player tile
        .dragon_pos (dragon_pos)
    );

    tile_renderer #(
        .TILE_PIXELS (TILE_PIXELS)
    ) tile_renderer0 (
        .clk        (clk),
        .reset      (reset),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .display_on (display_on),
        .player     (player),
        .dragon_pos (dragon_pos),
        .rgb        (rgb)
    );

endmodule

// ==== game_control.sv ====
`timescale 1ns/1ps

module game_control import game_pkg::*; #(
    parameter int        SWORD_FRAMES = 10,
    parameter tile_pos_t START_POS    = '{x: 4'd7, y: 4'd6}
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          frame_tick,
    input  buttons_t      pressed,
    output player_state_t player
);

    localparam int               CNT_W      = $clog2(SWORD_FRAMES + 1);
    localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(SWORD_FRAMES - 1);

    typedef enum logic {
        ST_IDLE,
        ST_ATTACK
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] frame_cnt;    // ticks spent swinging
    dir_t             move_dir;
    logic             move_req;
    logic             move_ok;

    // tile next to p, wraps mod 16 on both axes
    function automatic tile_pos_t neighbour(tile_pos_t p, dir_t d);
        tile_pos_t n;
        n = p;
        case (d)
            DIR_UP:    n.y = p.y - 1'b1;
            DIR_RIGHT: n.x = p.x + 1'b1;
            DIR_DOWN:  n.y = p.y + 1'b1;
            default:   n.x = p.x - 1'b1;
        endcase
        return n;
    endfunction

    // priority right > left > down > up
    always_comb begin
        move_req = 1'b1;
        move_dir = DIR_RIGHT;
        if (pressed.right) begin
            move_dir = DIR_RIGHT;
        end else if (pressed.left) begin
            move_dir = DIR_LEFT;
        end else if (pressed.down) begin
            move_dir = DIR_DOWN;
        end else if (pressed.up) begin
            move_dir = DIR_UP;
        end else begin
            move_req = 1'b0;            // nothing to do
        end
    end

    // boundary check for the chosen step
    always_comb begin
        case (move_dir)
            DIR_UP:    move_ok = player.pos.y > GRID_Y_MIN;
            DIR_RIGHT: move_ok = player.pos.x < GRID_X_MAX;
            DIR_DOWN:  move_ok = player.pos.y < GRID_Y_MAX;
            default:   move_ok = player.pos.x != '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // fsm, advances only on the frame tick
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!reset) begin
            state            <= ST_IDLE;
            frame_cnt        <= '0;
            player.pos       <= START_POS;
            player.facing    <= DIR_RIGHT;
            player.sword_on  <= 1'b0;
            player.sword_pos <= '0;
        end else if (frame_tick) begin
            case (state)
                ST_IDLE: begin
                    if (pressed.attack) begin       // attack beats movement
                        state            <= ST_ATTACK;
                        frame_cnt        <= '0;
                        player.sword_on  <= 1'b1;
                        player.sword_pos <= neighbour(player.pos, player.facing);
                    end else if (move_req) begin
                        player.facing <= move_dir;  // turn even when blocked
                        if (move_ok) begin
                            player.pos <= neighbour(player.pos, move_dir);
                        end
                    end
                end
                default: begin                      // swinging, inputs dropped
                    if (frame_cnt == LAST_FRAME) begin
                        state           <= ST_IDLE;
                        player.sword_on <= 1'b0;
                    end else begin
                        frame_cnt <= frame_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    ap_row_in_field: assert property (@(posedge clk) disable iff (!reset)
        (player.pos.y >= GRID_Y_MIN) && (player.pos.y <= GRID_Y_MAX))
        else $error("player row left the field");

endmodule

// ==== game_pkg.sv ====
package game_pkg;

    // grid coordinates, 16 columns by 12 rows
    typedef logic [3:0] tile_x_t;
    typedef logic [3:0] tile_y_t;

    typedef struct packed {
        tile_x_t x;                     // column, high nibble as in xxxx_yyyy
        tile_y_t y;                     // row
    } tile_pos_t;

    // facing codes match the 2-bit orientation field
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_t;

    typedef struct packed {
        logic attack;
        logic right;
        logic left;
        logic down;
        logic up;
    } buttons_t;

    typedef struct packed {
        tile_pos_t pos;
        dir_t      facing;
        logic      sword_on;
        tile_pos_t sword_pos;           // only meaningful while sword_on
    } player_state_t;

    // playable field, row 0 is kept clear
    localparam tile_x_t GRID_X_MAX = 4'd15;
    localparam tile_y_t GRID_Y_MIN = 4'd1;
    localparam tile_y_t GRID_Y_MAX = 4'd11;

endpackage

// ==== src.f ====
game_pkg.sv
video_pkg.sv
vga_timing.sv
button_latch.sv
game_control.sv
dragon_chaser.sv
tile_renderer.sv
dungeon_top.sv
dungeon_tb.sv

// ==== tile_renderer.sv ====
`timescale 1ns/1ps

module tile_renderer import game_pkg::*; import video_pkg::*; #(
    parameter int TILE_PIXELS = 40
) (
    input  logic          clk,
    input  logic          reset,
    input  pix_t          pix_x,
    input  pix_t          pix_y,
    input  logic          display_on,
    input  player_state_t player,
    input  tile_pos_t     dragon_pos,
    output rgb_t          rgb
);

    localparam int               SUB_W    = $clog2(TILE_PIXELS + 1);
    localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(TILE_PIXELS - 1);

    // tile index plus pixel offset inside the tile
    typedef struct packed {
        logic [3:0]       tile;
        logic [SUB_W-1:0] sub;
    } track_t;

    track_t    x_trk;               // position of the previous pixel
    track_t    y_trk;
    track_t    x_cur;
    track_t    y_cur;
    pix_t      x_prev;
    pix_t      y_prev;
    tile_pos_t here;
    rgb_t      colour;

    function automatic track_t advance(track_t t);
        track_t n;
        if (t.sub == SUB_LAST) begin
            n.tile = t.tile + 1'b1;     // next tile
            n.sub  = '0;
        end else begin
            n.tile = t.tile;
            n.sub  = t.sub + 1'b1;
        end
        return n;
    endfunction

    // coordinate 0 restarts, a changed coordinate steps by one pixel
    always_comb begin
        if (pix_x == '0) begin
            x_cur = '0;
        end else if (pix_x != x_prev) begin
            x_cur = advance(x_trk);
        end else begin
            x_cur = x_trk;
        end
        if (pix_y == '0) begin
            y_cur = '0;
        end else if (pix_y != y_prev) begin
            y_cur = advance(y_trk);     // new line
        end else begin
            y_cur = y_trk;
        end
    end

    assign here = '{x: x_cur.tile, y: y_cur.tile};

    // sword > player > dragon > floor
    always_comb begin
        if (!display_on) begin
            colour = COL_BLACK;
        end else if (player.sword_on && (here == player.sword_pos)) begin
            colour = COL_SWORD;
        end else if (here == player.pos) begin
            colour = COL_PLAYER;
        end else if (here == dragon_pos) begin
            colour = COL_DRAGON;
        end else begin
            case (player.facing)
                DIR_UP:    colour = BG_UP;
                DIR_RIGHT: colour = BG_RIGHT;
                DIR_DOWN:  colour = BG_DOWN;
                default:   colour = BG_LEFT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            x_trk  <= '0;
            y_trk  <= '0;
            x_prev <= '0;
            y_prev <= '0;
            rgb    <= COL_BLACK;
        end else begin
            x_trk  <= x_cur;
            y_trk  <= y_cur;
            x_prev <= pix_x;
            y_prev <= pix_y;
            rgb    <= colour;           // one clock behind pix_x/pix_y
        end
    end

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing import video_pkg::*; #(
    parameter int H_DISPLAY = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_DISPLAY = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic clk,
    input  logic reset,
    output pix_t pix_x,
    output pix_t pix_y,
    output logic display_on,
    output logic hsync,
    output logic vsync,
    output logic frame_tick
);

    // derived counter limits
    localparam pix_t H_END        = pix_t'(H_DISPLAY);
    localparam pix_t H_SYNC_START = pix_t'(H_DISPLAY + H_FRONT);
    localparam pix_t H_SYNC_END   = pix_t'(H_DISPLAY + H_FRONT + H_SYNC - 1);
    localparam pix_t H_MAX        = pix_t'(H_DISPLAY + H_FRONT + H_SYNC + H_BACK - 1);
    localparam pix_t H_TICK       = pix_t'(H_DISPLAY - 1);   // tick lands on H_END
    localparam pix_t V_END        = pix_t'(V_DISPLAY);
    localparam pix_t V_SYNC_START = pix_t'(V_DISPLAY + V_FRONT);
    localparam pix_t V_SYNC_END   = pix_t'(V_DISPLAY + V_FRONT + V_SYNC - 1);
    localparam pix_t V_MAX        = pix_t'(V_DISPLAY + V_FRONT + V_SYNC + V_BACK - 1);

    pix_t hpos;
    pix_t vpos;
    logic h_last;

    assign h_last = (hpos == H_MAX);

    always_ff @(posedge clk) begin
        if (!reset) begin
            hpos <= '0;
            vpos <= '0;
        end else begin
            hpos <= h_last ? '0 : hpos + 1'b1;
            if (h_last) begin
                vpos <= (vpos == V_MAX) ? '0 : vpos + 1'b1;   // next line
            end
        end
    end

    // sync pulses active high, one clock behind the counters
    always_ff @(posedge clk) begin
        if (!reset) begin
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            frame_tick <= 1'b0;
        end else begin
            hsync      <= (hpos >= H_SYNC_START) && (hpos <= H_SYNC_END);
            vsync      <= (vpos >= V_SYNC_START) && (vpos <= V_SYNC_END);
            frame_tick <= (hpos == H_TICK) && (vpos == V_END);
        end
    end

    assign display_on = (hpos < H_END) && (vpos < V_END);
    assign pix_x      = (hpos < H_END) ? hpos : '0;   // zero in blanking
    assign pix_y      = (vpos < V_END) ? vpos : '0;

    // game state may only change while the beam is off screen
    ap_tick_in_blank: assert property (@(posedge clk) disable iff (!reset)
        frame_tick |-> !display_on)
        else $error("frame_tick raised inside the visible area");

endmodule

// ==== video_pkg.sv ====
package video_pkg;

    typedef logic [9:0] pix_t;          // enough for 800 clocks per line

    // 2 bits per channel, fed to a resistor dac
    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    // ------------------------------------------------------------------------
    // flat tile colours
    // ------------------------------------------------------------------------
    localparam rgb_t COL_BLACK  = '{r: 2'b00, g: 2'b00, b: 2'b00};
    localparam rgb_t COL_PLAYER = '{r: 2'b11, g: 2'b11, b: 2'b11};   // white
    localparam rgb_t COL_SWORD  = '{r: 2'b11, g: 2'b11, b: 2'b00};   // yellow
    localparam rgb_t COL_DRAGON = '{r: 2'b00, g: 2'b11, b: 2'b11};   // cyan

    // floor colour follows where the player faces
    localparam rgb_t BG_UP    = '{r: 2'b11, g: 2'b00, b: 2'b00};
    localparam rgb_t BG_RIGHT = '{r: 2'b00, g: 2'b11, b: 2'b00};
    localparam rgb_t BG_DOWN  = '{r: 2'b00, g: 2'b00, b: 2'b11};
    localparam rgb_t BG_LEFT  = '{r: 2'b11, g: 2'b00, b: 2'b11};

endpackage
